/* tb.f */
+incdir+verif
hw/cavlc_syntax_pkg.sv
hw/cavlc_ctrl_pkg.sv
hw/cavlc_read_total_coeffs.sv
hw/cavlc_read_levels.sv
hw/cavlc_read_total_zeros.sv
hw/cavlc_read_run_befores.sv
hw/cavlc_fsm.sv
hw/cavlc_top.sv
verif/cavlc_tb.sv

/* Bender.yml */
package:
  name: cavlc_chroma_dc

sources:
  - hw/cavlc_syntax_pkg.sv
  - hw/cavlc_ctrl_pkg.sv
  - hw/cavlc_read_total_coeffs.sv
  - hw/cavlc_read_levels.sv
  - hw/cavlc_read_total_zeros.sv
  - hw/cavlc_read_run_befores.sv
  - hw/cavlc_fsm.sv
  - hw/cavlc_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/cavlc_tb.sv

/* verif/cavlc_streams.svh */
// chroma dc test streams
// coded bits left aligned, first bit at the msb, with the hand-decoded block
`ifndef cavlc_streams_svh
`define cavlc_streams_svh

// one coded block and the result it must decode to
typedef struct packed {
    logic [63:0]  bits;
    logic [6:0]   end_bit;
    logic [2:0]   total_coeff;
    coeff_block_t coeffs;
} stream_t;

localparam int num_streams = 7;

localparam stream_t streams [0:num_streams-1] = '{
    // token 01, empty block
    '{bits: 64'h4000_0000_0000_0000, end_bit: 7'd2, total_coeff: 3'd0,
      coeffs: '{c0: 9'sd0, c1: 9'sd0, c2: 9'sd0, c3: 9'sd0}},
    // tc 1 t1 1, sign -, total_zeros 2 as 001
    '{bits: 64'hC800_0000_0000_0000, end_bit: 7'd5, total_coeff: 3'd1,
      coeffs: '{c0: 9'sd0, c1: 9'sd0, c2: -9'sd1, c3: 9'sd0}},
    // tc 3 t1 2, signs + and -, prefix 1 with the +2 step gives -2
    // total_zeros 1, then run 1 and the rest packed at the front
    '{bits: 64'h04A0_0000_0000_0000, end_bit: 7'd13, total_coeff: 3'd3,
      coeffs: '{c0: -9'sd2, c1: -9'sd1, c2: 9'sd0, c3: 9'sd1}},
    // tc 4 t1 0, levels +4 -4 +8 -3
    // suffixLength runs 0, 2, 2, 3 and total_zeros is not coded
    '{bits: 64'h082E_3680_0000_0000, end_bit: 7'd25, total_coeff: 3'd4,
      coeffs: '{c0: -9'sd3, c1: 9'sd8, c2: -9'sd4, c3: 9'sd4}},
    // tc 1 t1 0, prefix 14 escape with 4-bit suffix 0101, level -11
    // total_zeros 3 puts it in the last slot
    '{bits: 64'h1C00_0A80_0000_0000, end_bit: 7'd28, total_coeff: 3'd1,
      coeffs: '{c0: 9'sd0, c1: 9'sd0, c2: 9'sd0, c3: -9'sd11}},
    // tc 2 t1 1, sign +, level +2, total_zeros 2, run 1 as 01
    '{bits: 64'h1910_0000_0000_0000, end_bit: 7'd12, total_coeff: 3'd2,
      coeffs: '{c0: 9'sd0, c1: 9'sd2, c2: 9'sd0, c3: 9'sd1}},
    // tc 4 t1 3, signs - + -, last level +2 without the +2 step
    '{bits: 64'h0148_0000_0000_0000, end_bit: 7'd13, total_coeff: 3'd4,
      coeffs: '{c0: 9'sd2, c1: -9'sd1, c2: 9'sd1, c3: -9'sd1}}
};

`endif

/* verif/cavlc_tb.sv */
// cavlc chroma dc decoder testbench
// feeds each test stream through a moving 16-bit window, once with ena
// held high and once with random stalls, and checks with assertions
`timescale 1ns/1ps

module cavlc_tb;
    import cavlc_ctrl_pkg::*;
    import cavlc_syntax_pkg::*;

    `include "cavlc_streams.svh"

    localparam int unsigned random_seed = 32'h6d27_ce26;
    // enabled cycles per block, start and done included, rounded up
    localparam int block_cycles = 14;
    // two passes, stalls at most every other cycle, plus reset and margin
    localparam int timeout_cycles = 2 * num_streams * block_cycles * 2 + 32;

    logic                clk;
    logic                reset;
    logic                ena;
    logic                start;
    logic [window_w-1:0] rbsp;
    coeff_block_t        coeffs;
    logic [2:0]          total_coeff;
    len_t                len;
    logic                idle;
    logic                valid;

    // bit pointer into the current stream and what it should decode to
    int unsigned ptr;
    stream_t     expected;
    // starts not yet answered by a valid
    int          pending;
    int          cycle_count;
    int          mismatch_count;
    int          protocol_count;
    int          timeout_count;

    cavlc_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .ena         (ena),
        .start       (start),
        .rbsp        (rbsp),
        .coeffs      (coeffs),
        .total_coeff (total_coeff),
        .len         (len),
        .idle        (idle),
        .valid       (valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 16 stream bits at bit offset p, zeros past the end
    function automatic logic [window_w-1:0] window_at(input int s, input int unsigned p);
        logic [63:0] shifted;
        shifted = streams[s].bits << p;
        return shifted[63 -: window_w];
    endfunction

    // ------------------------------
    // stimulus
    // ------------------------------
    // called right after a rising edge, returns on the edge that saw valid
    task automatic decode_stream(input int s, input bit use_gaps);
        logic ena_n;
        logic low_last;
        logic got_valid;
        logic valid_seen;
        len_t len_seen;
        expected  = streams[s];
        ptr       = 0;
        low_last  = 1'b0;
        got_valid = 1'b0;
        // start always goes out with ena high so it is never dropped
        start <= 1'b1;
        ena   <= 1'b1;
        rbsp  <= window_at(s, 0);
        @(posedge clk);
        start <= 1'b0;
        while (!got_valid) begin
            ena_n = 1'b1;
            // never two stalled cycles in a row
            if (use_gaps && !low_last) begin
                ena_n = ($urandom % 2) == 0;
            end
            low_last = !ena_n;
            ena  <= ena_n;
            rbsp <= window_at(s, ptr);
            // mid-cycle, len and valid have settled
            @(negedge clk);
            len_seen   = len;
            valid_seen = valid;
            @(posedge clk);
            // the window moves only on edges that the dut took
            if (ena_n) begin
                got_valid = valid_seen;
                ptr       = ptr + len_seen;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(start && ena) - int'(valid);
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    reset_idle: assert property (@(posedge clk) reset |=> idle)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: idle = %b, expected 1", $time, $sampled(idle));
        end

    reset_valid: assert property (@(posedge clk) reset |=> !valid)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: valid = %b, expected 0", $time, $sampled(valid));
        end

    reset_len: assert property (@(posedge clk) reset |=> len == '0)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: len = %0d, expected 0", $time, $sampled(len));
        end

    block_coeffs: assert property (@(posedge clk) disable iff (reset)
        valid |-> coeffs == expected.coeffs)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: coeffs = %h, expected %h",
                     $time, $sampled(coeffs), $sampled(expected.coeffs));
        end

    block_total_coeff: assert property (@(posedge clk) disable iff (reset)
        valid |-> total_coeff == expected.total_coeff)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: total_coeff = %0d, expected %0d",
                     $time, $sampled(total_coeff), $sampled(expected.total_coeff));
        end

    // the sum of len must land exactly on the end of the stream
    block_end: assert property (@(posedge clk) disable iff (reset)
        valid |-> ptr == int'(expected.end_bit))
        else begin
            mismatch_count++;
            $display("mismatch at %0t: bit pointer = %0d, expected %0d",
                     $time, $sampled(ptr), $sampled(expected.end_bit));
        end

    stall_hold: assert property (@(posedge clk) disable iff (reset)
        !ena |=> $stable(coeffs) && $stable(total_coeff) && $stable(len) && $stable(idle))
        else begin
            protocol_count++;
            $display("outputs changed at %0t while ena was low", $time);
        end

    one_valid: assert property (@(posedge clk) disable iff (reset)
        valid |-> pending == 1)
        else begin
            protocol_count++;
            $display("valid at %0t does not answer exactly one start", $time);
        end

    one_start: assert property (@(posedge clk) disable iff (reset)
        (start && ena) |-> pending == 0)
        else begin
            protocol_count++;
            $display("start at %0t while the previous block had no valid", $time);
        end

    idle_after: assert property (@(posedge clk) disable iff (reset)
        valid |=> idle)
        else begin
            protocol_count++;
            $display("decoder not idle at %0t on the cycle after valid", $time);
        end

    // ------------------------------
    // run control
    // ------------------------------
    task automatic finish_run();
        $display("checks done: %0d mismatches, %0d protocol errors, %0d timeouts",
                 mismatch_count, protocol_count, timeout_count);
        if (mismatch_count == 0 && protocol_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        timeout_count++;
        $display("timeout: decoding did not finish within %0d cycles", timeout_cycles);
        finish_run();
    end

    initial begin
        void'($urandom(random_seed));
        mismatch_count = 0;
        protocol_count = 0;
        timeout_count  = 0;
        expected       = '0;
        ptr            = 0;
        reset          = 1'b1;
        ena            = 1'b0;
        start          = 1'b0;
        rbsp           = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // first pass with ena held high, second with random stalls
        for (int pass = 0; pass < 2; pass++) begin
            for (int s = 0; s < num_streams; s++) begin
                decode_stream(s, pass == 1);
            end
        end
        // give the checks on the last valid their next edge
        repeat (2) @(posedge clk);
        finish_run();
    end

endmodule

/* hw/cavlc_top.sv */
// cavlc chroma dc decoder top
// connects the coeff_token, level, total_zeros and run_before readers
// to the fsm that sequences them
`timescale 1ns/1ps

module cavlc_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ena,
    input  logic                                start,
    input  logic [cavlc_ctrl_pkg::window_w-1:0] rbsp,
    output cavlc_syntax_pkg::coeff_block_t      coeffs,
    output logic [2:0]                          total_coeff,
    output cavlc_ctrl_pkg::len_t                len,
    output logic                                idle,
    output logic                                valid
);
    import cavlc_ctrl_pkg::*;
    import cavlc_syntax_pkg::*;

    cavlc_state_t state;
    idx_t         i;
    token_t       token;
    token_t       token_comb;
    coeff_block_t levels;
    total_zeros_t total_zeros;
    total_zeros_t zero_left;
    len_t         len_total_coeffs;
    len_t         len_levels;
    len_t         len_total_zeros;
    len_t         len_run_before;

    assign total_coeff = token.total_coeff;

    // ------------------------------
    // readers
    // ------------------------------
    cavlc_read_total_coeffs i_read_total_coeffs (
        .clk        (clk),
        .reset      (reset),
        .ena        (ena),
        .state      (state),
        .rbsp       (rbsp),
        .token      (token),
        .token_comb (token_comb),
        .len        (len_total_coeffs)
    );

    cavlc_read_levels i_read_levels (
        .clk    (clk),
        .reset  (reset),
        .ena    (ena),
        .state  (state),
        .i      (i),
        .token  (token),
        .rbsp   (rbsp),
        .levels (levels),
        .len    (len_levels)
    );

    cavlc_read_total_zeros i_read_total_zeros (
        .state       (state),
        .rbsp        (rbsp),
        .token       (token),
        .total_zeros (total_zeros),
        .len         (len_total_zeros)
    );

    cavlc_read_run_befores i_read_run_befores (
        .clk         (clk),
        .reset       (reset),
        .ena         (ena),
        .state       (state),
        .i           (i),
        .rbsp        (rbsp),
        .total_zeros (total_zeros),
        .levels      (levels),
        .zero_left   (zero_left),
        .coeffs      (coeffs),
        .len         (len_run_before)
    );

    // ------------------------------
    // sequencing
    // ------------------------------
    cavlc_fsm i_fsm (
        .clk              (clk),
        .reset            (reset),
        .ena              (ena),
        .start            (start),
        .token            (token),
        .token_comb       (token_comb),
        .zero_left        (zero_left),
        .len_total_coeffs (len_total_coeffs),
        .len_levels       (len_levels),
        .len_total_zeros  (len_total_zeros),
        .len_run_before   (len_run_before),
        .state            (state),
        .i                (i),
        .len              (len),
        .idle             (idle),
        .valid            (valid)
    );

endmodule

/* hw/cavlc_fsm.sv */
// cavlc decoder fsm
// steps through the syntax elements, counts the level index
// and picks the consumed length of the active reader
`timescale 1ns/1ps

module cavlc_fsm (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ena,
    input  logic                           start,
    input  cavlc_syntax_pkg::token_t       token,
    input  cavlc_syntax_pkg::token_t       token_comb,
    input  cavlc_syntax_pkg::total_zeros_t zero_left,
    input  cavlc_ctrl_pkg::len_t           len_total_coeffs,
    input  cavlc_ctrl_pkg::len_t           len_levels,
    input  cavlc_ctrl_pkg::len_t           len_total_zeros,
    input  cavlc_ctrl_pkg::len_t           len_run_before,
    output cavlc_ctrl_pkg::cavlc_state_t   state,
    output cavlc_ctrl_pkg::idx_t           i,
    output cavlc_ctrl_pkg::len_t           len,
    output logic                           idle,
    output logic                           valid
);
    import cavlc_ctrl_pkg::*;
    import cavlc_syntax_pkg::*;

    cavlc_state_t state_next;
    cavlc_state_t after_levels;
    logic         run_cycle;

    // a full block has no zeros, so total_zeros is not coded
    assign after_levels = (token.total_coeff == 3'(max_coeff)) ? st_run_before
                                                               : st_total_zeros;

    // same rule the run_before reader uses to read a code
    assign run_cycle = zero_left != 2'd0 && ({1'b0, i} + 3'd1) < token.total_coeff;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_total_coeffs;
                end
            end
            st_total_coeffs: begin
                if (token_comb.total_coeff == 3'd0) begin
                    state_next = st_done;
                end else if (token_comb.trailing_ones != 2'd0) begin
                    state_next = st_t1s;
                end else begin
                    state_next = st_level_prefix;
                end
            end
            // i still equals TrailingOnes here
            st_t1s: begin
                state_next = ({1'b0, i} < token.total_coeff) ? st_level_prefix
                                                             : after_levels;
            end
            st_level_prefix: state_next = st_level_suffix;
            st_level_suffix: begin
                state_next = ({1'b0, i} + 3'd1 < token.total_coeff) ? st_level_prefix
                                                                    : after_levels;
            end
            st_total_zeros:  state_next = st_run_before;
            // the last run_before cycle places the remaining levels
            st_run_before:   state_next = run_cycle ? st_run_before : st_done;
            st_done:         state_next = st_idle;
            default:         state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            i     <= '0;
        end else if (ena) begin
            state <= state_next;
            case (state)
                // levels after the trailing ones start at index t1
                st_total_coeffs: i <= token_comb.trailing_ones;
                st_t1s: begin
                    if (state_next != st_level_prefix) begin
                        i <= '0;
                    end
                end
                // back to 0 for the run_before pass
                st_level_suffix: begin
                    i <= (state_next == st_level_prefix) ? i + 2'd1 : 2'd0;
                end
                st_run_before: begin
                    if (run_cycle) begin
                        i <= i + 2'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    // consumed length of the reader that owns the state
    always_comb begin
        case (state)
            st_total_coeffs: len = len_total_coeffs;
            st_t1s, st_level_prefix, st_level_suffix: len = len_levels;
            st_total_zeros:  len = len_total_zeros;
            st_run_before:   len = len_run_before;
            default:         len = '0;
        endcase
    end

    assign idle  = state == st_idle;
    // one pulse per block even when st_done is stalled
    assign valid = ena && state == st_done;

    state_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot(state));

    start_when_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> idle);

endmodule

/* hw/cavlc_read_run_befores.sv */
// run_before reader
// tracks zerosLeft and places levels into the zigzag coefficient block
// placement runs from the last nonzero coefficient downwards
`timescale 1ns/1ps

module cavlc_read_run_befores (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ena,
    input  cavlc_ctrl_pkg::cavlc_state_t        state,
    input  cavlc_ctrl_pkg::idx_t                i,
    input  logic [cavlc_ctrl_pkg::window_w-1:0] rbsp,
    input  cavlc_syntax_pkg::total_zeros_t      total_zeros,
    input  cavlc_syntax_pkg::coeff_block_t      levels,
    output cavlc_syntax_pkg::total_zeros_t      zero_left,
    output cavlc_syntax_pkg::coeff_block_t      coeffs,
    output cavlc_ctrl_pkg::len_t                len
);
    import cavlc_ctrl_pkg::*;
    import cavlc_syntax_pkg::*;

    coeff_t [0:max_coeff-1] lv;
    coeff_t [0:max_coeff-1] blk;
    // zigzag slot for the next level
    idx_t         pos;
    logic [2:0]   num_levels;
    logic         run_cycle;
    total_zeros_t run;
    len_t         run_len;

    assign lv     = levels;
    assign coeffs = blk;

    // decoded levels are never zero, so this is TotalCoeff
    always_comb begin
        num_levels = '0;
        for (int k = 0; k < max_coeff; k++) begin
            if (lv[k] != '0) begin
                num_levels = num_levels + 3'd1;
            end
        end
    end

    // read a run while zeros remain and more than one level is left
    assign run_cycle = zero_left != 2'd0 && ({1'b0, i} + 3'd1) < num_levels;

    // ------------------------------
    // run_before table
    // ------------------------------
    always_comb begin
        run     = 2'd0;
        run_len = 5'd0;
        case (zero_left)
            2'd1: begin
                run     = rbsp[window_w-1] ? 2'd0 : 2'd1;
                run_len = 5'd1;
            end
            2'd2: begin
                if (rbsp[window_w-1]) begin
                    run_len = 5'd1;
                end else begin
                    run     = rbsp[window_w-2] ? 2'd1 : 2'd2;
                    run_len = 5'd2;
                end
            end
            2'd3: begin
                // 11 -> 0 down to 00 -> 3
                run     = ~rbsp[window_w-1 -: 2];
                run_len = 5'd2;
            end
            default: ;
        endcase
    end

    assign len = (state == st_run_before && run_cycle) ? run_len : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            zero_left <= '0;
            pos       <= '0;
            blk       <= '0;
        end else if (ena) begin
            case (state)
                st_total_coeffs: begin
                    // a full block skips total_zeros and keeps these
                    zero_left <= '0;
                    pos       <= idx_t'(max_coeff - 1);
                    blk       <= '0;
                end
                st_total_zeros: begin
                    zero_left <= total_zeros;
                    pos       <= idx_t'(num_levels + 3'(total_zeros) - 3'd1);
                end
                st_run_before: begin
                    if (run_cycle) begin
                        blk[pos]  <= lv[i];
                        pos       <= pos - idx_t'(run) - 2'd1;
                        zero_left <= zero_left - run;
                    end else begin
                        // leaving for st_done, rest go in back to back
                        for (int k = 0; k < max_coeff; k++) begin
                            if (k >= i && k < num_levels) begin
                                blk[pos - idx_t'(k - i)] <= lv[k];
                            end
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // a run must leave a slot for every level still to be placed
    run_range: assert property (@(posedge clk) disable iff (reset)
        (ena && state == st_run_before && run_cycle) |->
            3'(pos) >= 3'(run) + num_levels - 3'(i) - 3'd1);

endmodule

/* hw/cavlc_read_total_zeros.sv */
// chroma dc total_zeros reader
// combinational lookup in the three tables picked by TotalCoeff
`timescale 1ns/1ps

module cavlc_read_total_zeros (
    input  cavlc_ctrl_pkg::cavlc_state_t        state,
    input  logic [cavlc_ctrl_pkg::window_w-1:0] rbsp,
    input  cavlc_syntax_pkg::token_t            token,
    output cavlc_syntax_pkg::total_zeros_t      total_zeros,
    output cavlc_ctrl_pkg::len_t                len
);
    import cavlc_ctrl_pkg::*;

    logic [2:0] code;
    len_t       code_len;

    // codes are at most 3 bits
    assign code = rbsp[window_w-1 -: 3];

    always_comb begin
        case (token.total_coeff)
            3'd1: begin
                casez (code)
                    3'b1??:  {total_zeros, code_len} = {2'd0, 5'd1};
                    3'b01?:  {total_zeros, code_len} = {2'd1, 5'd2};
                    3'b001:  {total_zeros, code_len} = {2'd2, 5'd3};
                    default: {total_zeros, code_len} = {2'd3, 5'd3};
                endcase
            end
            3'd2: begin
                casez (code)
                    3'b1??:  {total_zeros, code_len} = {2'd0, 5'd1};
                    3'b01?:  {total_zeros, code_len} = {2'd1, 5'd2};
                    default: {total_zeros, code_len} = {2'd2, 5'd2};
                endcase
            end
            3'd3: begin
                {total_zeros, code_len} = {~code[2] ? 2'd1 : 2'd0, 5'd1};
            end
            // TotalCoeff 0 or 4 never reaches st_total_zeros
            default: {total_zeros, code_len} = {2'd0, 5'd0};
        endcase
    end

    assign len = (state == st_total_zeros) ? code_len : '0;

endmodule

/* hw/cavlc_read_levels.sv */
// level reader
// trailing-one signs, level_prefix and level_suffix into the level list
// levels are kept in decode order, highest frequency first
`timescale 1ns/1ps

module cavlc_read_levels (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ena,
    input  cavlc_ctrl_pkg::cavlc_state_t        state,
    input  cavlc_ctrl_pkg::idx_t                i,
    input  cavlc_syntax_pkg::token_t            token,
    input  logic [cavlc_ctrl_pkg::window_w-1:0] rbsp,
    output cavlc_syntax_pkg::coeff_block_t      levels,
    output cavlc_ctrl_pkg::len_t                len
);
    import cavlc_ctrl_pkg::*;
    import cavlc_syntax_pkg::*;

    coeff_t [0:max_coeff-1] lv;
    // suffixLength, 0 to 6
    logic [2:0]  suffix_len;
    logic [2:0]  sl_first;
    logic [2:0]  sl_next;
    logic [3:0]  prefix;
    len_t        lead_zeros;
    len_t        suffix_size;
    logic [11:0] level_suffix;
    // wide enough for the prefix 15 escape
    logic [12:0] level_code;
    logic [12:0] level_mag;
    coeff_t      level;

    assign levels = lv;

    // ------------------------------
    // level_prefix
    // ------------------------------
    // count leading zeros, the first one found wins
    always_comb begin
        lead_zeros = len_t'(window_w);
        for (int k = 0; k < window_w; k++) begin
            if (rbsp[window_w-1-k] && lead_zeros == len_t'(window_w)) begin
                lead_zeros = len_t'(k);
            end
        end
    end

    // ------------------------------
    // level_suffix and levelCode
    // ------------------------------
    always_comb begin
        // escape sizes at prefix 14 and 15
        if (prefix == 4'd14 && suffix_len == 3'd0) begin
            suffix_size = 5'd4;
        end else if (prefix == 4'd15) begin
            suffix_size = 5'd12;
        end else begin
            suffix_size = len_t'(suffix_len);
        end
        if (suffix_size == 5'd0) begin
            level_suffix = '0;
        end else begin
            level_suffix = 12'(rbsp >> (window_w - suffix_size));
        end

        level_code = (13'(prefix) << suffix_len) + 13'(level_suffix);
        if (prefix == 4'd15 && suffix_len == 3'd0) begin
            level_code = level_code + 13'd15;
        end
        // first level after fewer than 3 trailing ones cannot be +-1
        if (i == token.trailing_ones && token.trailing_ones < 2'd3) begin
            level_code = level_code + 13'd2;
        end

        // even codes positive, odd codes negative
        level_mag = (level_code >> 1) + 13'd1;
        level     = level_code[0] ? -coeff_t'(level_mag) : coeff_t'(level_mag);

        // suffixLength adaptation
        sl_first = (suffix_len == 3'd0) ? 3'd1 : suffix_len;
        if (level_mag > (13'd3 << (sl_first - 3'd1)) && sl_first < 3'd6) begin
            sl_next = sl_first + 3'd1;
        end else begin
            sl_next = sl_first;
        end
    end

    // bits used by this reader in its own states
    always_comb begin
        case (state)
            st_t1s:          len = len_t'(token.trailing_ones);
            st_level_prefix: len = lead_zeros + 5'd1;
            st_level_suffix: len = suffix_size;
            default:         len = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            suffix_len <= '0;
            prefix     <= '0;
        end else if (ena) begin
            // chroma dc never has TotalCoeff above 10, so start at 0
            if (state == st_total_coeffs) begin
                suffix_len <= '0;
            end
            if (state == st_level_prefix) begin
                prefix <= lead_zeros[3:0];
            end
            if (state == st_level_suffix) begin
                suffix_len <= sl_next;
            end
        end
    end

    // level list, cleared per block so unused slots read zero
    always_ff @(posedge clk) begin
        if (ena) begin
            case (state)
                st_total_coeffs: lv <= '0;
                st_t1s: begin
                    // sign bit 1 means -1
                    for (int k = 0; k < 3; k++) begin
                        if (k < token.trailing_ones) begin
                            lv[k] <= rbsp[window_w-1-k] ? -9'sd1 : 9'sd1;
                        end
                    end
                end
                st_level_suffix: lv[i] <= level;
                default: ;
            endcase
        end
    end

    // the caller window must hold a one within the first 16 bits
    prefix_range: assert property (@(posedge clk) disable iff (reset)
        (ena && state == st_level_prefix) |-> lead_zeros <= 5'd15);

endmodule

/* hw/cavlc_read_total_coeffs.sv */
// chroma dc coeff_token reader
// decodes TotalCoeff and TrailingOnes from the nC = -1 table
`timescale 1ns/1ps

module cavlc_read_total_coeffs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ena,
    input  cavlc_ctrl_pkg::cavlc_state_t        state,
    input  logic [cavlc_ctrl_pkg::window_w-1:0] rbsp,
    output cavlc_syntax_pkg::token_t            token,
    output cavlc_syntax_pkg::token_t            token_comb,
    output cavlc_ctrl_pkg::len_t                len
);
    import cavlc_ctrl_pkg::*;

    // table entry as {total_coeff, trailing_ones, code length}
    logic [9:0] entry;

    // ------------------------------
    // coeff_token table, nC = -1
    // ------------------------------
    // the longest code is 8 bits, every 8-bit prefix hits one entry
    always_comb begin
        casez (rbsp[window_w-1 -: 8])
            8'b1???????: entry = {3'd1, 2'd1, 5'd1};
            8'b01??????: entry = {3'd0, 2'd0, 5'd2};
            8'b001?????: entry = {3'd2, 2'd2, 5'd3};
            8'b000111??: entry = {3'd1, 2'd0, 5'd6};
            8'b000100??: entry = {3'd2, 2'd0, 5'd6};
            8'b000110??: entry = {3'd2, 2'd1, 5'd6};
            8'b000101??: entry = {3'd3, 2'd3, 5'd6};
            8'b000011??: entry = {3'd3, 2'd0, 5'd6};
            8'b000010??: entry = {3'd4, 2'd0, 5'd6};
            8'b0000011?: entry = {3'd3, 2'd1, 5'd7};
            8'b0000010?: entry = {3'd3, 2'd2, 5'd7};
            8'b0000000?: entry = {3'd4, 2'd3, 5'd7};
            8'b00000011: entry = {3'd4, 2'd1, 5'd8};
            default:     entry = {3'd4, 2'd2, 5'd8};
        endcase
    end

    // combinational copy lets the fsm branch out of st_total_coeffs
    assign token_comb = entry[9:5];
    assign len        = entry[4:0];

    // registered copy serves all later states
    always_ff @(posedge clk) begin
        if (reset) begin
            token <= '0;
        end else if (ena && state == st_total_coeffs) begin
            token <= token_comb;
        end
    end

endmodule

/* hw/cavlc_ctrl_pkg.sv */
// cavlc control package
// decoder state encoding, bit window width and index types
package cavlc_ctrl_pkg;

    // rbsp bits visible to the decoder, first bit at the msb
    localparam int window_w = 16;

    // bits consumed in one cycle, 0 to 16
    typedef logic [4:0] len_t;

    // one-hot decoder states
    typedef enum logic [7:0] {
        st_idle         = 8'b0000_0001,
        st_total_coeffs = 8'b0000_0010,
        st_t1s          = 8'b0000_0100,
        st_level_prefix = 8'b0000_1000,
        st_level_suffix = 8'b0001_0000,
        st_total_zeros  = 8'b0010_0000,
        st_run_before   = 8'b0100_0000,
        st_done         = 8'b1000_0000
    } cavlc_state_t;

    // level or coefficient index
    typedef logic [1:0] idx_t;

endpackage

/* hw/cavlc_syntax_pkg.sv */
// cavlc syntax package
// coefficient, level and coeff_token types for chroma dc 2x2 blocks
package cavlc_syntax_pkg;

    // one chroma dc block holds 2x2 coefficients
    localparam int max_coeff = 4;

    // signed coefficient or level value
    typedef logic signed [8:0] coeff_t;

    // four coefficients, c0 comes first in zigzag order
    typedef struct packed {
        coeff_t c0;
        coeff_t c1;
        coeff_t c2;
        coeff_t c3;
    } coeff_block_t;

    // decoded coeff_token
    typedef struct packed {
        logic [2:0] total_coeff;
        logic [1:0] trailing_ones;
    } token_t;

    // zeros ahead of the last coefficient, 0 to 3
    typedef logic [1:0] total_zeros_t;

endpackage
